/* hw/game_pkg.sv */
package game_pkg;

   // game phases, IDLE is the reset phase
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      OVER = 2'd2,
      WIN  = 2'd3
   } state_t;

   // one bit per lane, used for lamps and buttons
   typedef logic [3:0] lamp_t;

   // lane index picked by the random generator
   typedef logic [1:0] lane_t;

   // divider terminal count
   typedef logic [3:0] rate_t;

   typedef logic [3:0] score_t;
   typedef logic [7:0] timer_t;

   // score that ends the game in WIN
   localparam score_t win_score = 4'd8;

   // clock cycles allowed per round before timeout
   localparam timer_t round_cycles = 8'd200;

   // LFSR reset values, never all zero
   localparam lane_t lfsr_seed_a = 2'd3;
   localparam lane_t lfsr_seed_b = 2'd2;

endpackage

/* hw/button_sync.sv */
module button_sync
   import game_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  lamp_t buttons,
   input  logic  start,
   output lamp_t press,
   output logic  start_pulse,
   output logic  any_press
);

   // bit 4 is start, bits 3:0 are the lane buttons
   logic [4:0] raw;
   logic [4:0] sync_meta;
   logic [4:0] sync;
   logic [4:0] sync_hist;
   logic [4:0] pulse;

   assign raw = {start, buttons};

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         sync_meta <= '0;
         sync      <= '0;
         sync_hist <= '0;
         pulse     <= '0;
      end
      else begin
         sync_meta <= raw;
         sync      <= sync_meta;
         sync_hist <= sync;
         // rising edge, registered so the pulse is glitch free
         pulse     <= sync & ~sync_hist;
      end
   end

   assign press       = pulse[3:0];
   assign start_pulse = pulse[4];

   // any lane action restarts the dividers
   assign any_press = |pulse[3:0];

endmodule

/* hw/tick_divider.sv */
module tick_divider
   import game_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  restart,
   input  rate_t rate,
   output logic  step
);

   rate_t count;
   rate_t last;

   // rate of 0 or 1 means a strobe every cycle
   assign last = (rate <= rate_t'(1)) ? '0 : rate - rate_t'(1);

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
         step  <= 1'b0;
      end
      else if (restart) begin
         count <= '0;
         step  <= 1'b0;
      end
      // >= so a rate lowered mid count still wraps
      else if (count >= last) begin
         count <= '0;
         step  <= 1'b1;
      end
      else begin
         count <= count + rate_t'(1);
         step  <= 1'b0;
      end
   end

endmodule

/* hw/random_generator.sv */
module random_generator
   import game_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   restart,
   input  rate_t  rate_a,
   input  rate_t  rate_b,
   input  state_t state,
   output lane_t  lane
);

   logic  step_a;
   logic  step_b;
   lane_t lfsr_a;
   lane_t lfsr_b;
   lane_t lfsr_a_next;
   lane_t lfsr_b_next;
   logic  feedback_a;
   logic  feedback_b;
   logic  running;

   // separate step rates for the two LFSRs
   tick_divider tick_div_a (
      .clk     (clk),
      .rst_n   (rst_n),
      .restart (restart),
      .rate    (rate_a),
      .step    (step_a)
   );

   tick_divider tick_div_b (
      .clk     (clk),
      .rst_n   (rst_n),
      .restart (restart),
      .rate    (rate_b),
      .step    (step_b)
   );

   assign running = (state == RUN);

   // x^2 + x + 1 feedback
   assign feedback_a = lfsr_a[1] ^ lfsr_a[0];
   assign feedback_b = lfsr_b[1] ^ lfsr_b[0];

   always_comb begin
      lfsr_a_next = lfsr_a;
      lfsr_b_next = lfsr_b;
      // hold outside RUN so the next game starts elsewhere
      if (running) begin
         if (step_a) begin
            lfsr_a_next = {lfsr_a[0], feedback_a};
         end
         if (step_b) begin
            lfsr_b_next = {lfsr_b[0], feedback_b};
         end
      end
   end

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         lfsr_a <= lfsr_seed_a;
      end
      else begin
         lfsr_a <= lfsr_a_next;
      end
   end

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         lfsr_b <= lfsr_seed_b;
      end
      else begin
         lfsr_b <= lfsr_b_next;
      end
   end

   // combined lane choice, zero when not playing
   assign lane = running ? (lfsr_a ^ lfsr_b) : '0;

endmodule

/* hw/game_fsm.sv */
module game_fsm
   import game_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  lamp_t  press,
   input  logic   start_pulse,
   input  lane_t  lane,
   output state_t state,
   output score_t score,
   output lamp_t  lamps
);

   state_t state_next;
   score_t score_next;
   score_t score_inc;
   lane_t  target;
   lane_t  target_next;
   timer_t timer;
   timer_t timer_next;
   timer_t timer_load;
   lamp_t  target_hot;
   logic   hit;
   logic   wrong;
   logic   timeout;

   // timer counts down to zero, so load one less than the round length
   assign timer_load = round_cycles - timer_t'(1);

   assign target_hot = lamp_t'(4'b0001 << target);
   assign score_inc  = score + score_t'(1);

   // exactly the lit button, anything else nonzero is a miss
   assign hit     = (press == target_hot);
   assign wrong   = (press != '0) && !hit;
   assign timeout = (timer == '0);

   always_comb begin
      state_next  = state;
      score_next  = score;
      target_next = target;
      timer_next  = timer;

      case (state)
         IDLE, OVER, WIN: begin
            if (start_pulse) begin
               state_next  = RUN;
               score_next  = '0;
               target_next = lane;
               timer_next  = timer_load;
            end
         end

         RUN: begin
            // start is ignored while a game runs
            if (hit) begin
               score_next = score_inc;
               if (score_inc == win_score) begin
                  state_next = WIN;
               end
               else begin
                  // new round
                  target_next = lane;
                  timer_next  = timer_load;
               end
            end
            else if (wrong) begin
               state_next = OVER;
            end
            else if (timeout) begin
               state_next = OVER;
            end
            else begin
               timer_next = timer - timer_t'(1);
            end
         end

         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         score <= '0;
      end
      else begin
         state <= state_next;
         score <= score_next;
      end
   end

   always_ff @(posedge clk, negedge rst_n) begin
      if (!rst_n) begin
         target <= '0;
         timer  <= '0;
      end
      else begin
         target <= target_next;
         timer  <= timer_next;
      end
   end

   // lamps only while a round is live
   assign lamps = (state == RUN) ? target_hot : '0;

endmodule

/* hw/game_top.sv */
module game_top
   import game_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  lamp_t  buttons,
   input  logic   start,
   input  rate_t  rate_a,
   input  rate_t  rate_b,
   output lamp_t  lamps,
   output state_t state,
   output score_t score
);

   lamp_t press;
   logic  start_pulse;
   logic  any_press;
   lane_t lane;

   // synchronised edge pulses from the player inputs
   button_sync button_sync_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .buttons     (buttons),
      .start       (start),
      .press       (press),
      .start_pulse (start_pulse),
      .any_press   (any_press)
   );

   // press timing reseeds the divider phase
   random_generator random_generator_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .restart (any_press),
      .rate_a  (rate_a),
      .rate_b  (rate_b),
      .state   (state),
      .lane    (lane)
   );

   game_fsm game_fsm_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .press       (press),
      .start_pulse (start_pulse),
      .lane        (lane),
      .state       (state),
      .score       (score),
      .lamps       (lamps)
   );

endmodule

/* verif/tb_game_top.sv */
module tb_game_top
   import game_pkg::*;
;

   localparam int max_steps    = 64;
   localparam int check_wait   = 8;
   localparam int press_cycles = 2;
   localparam int reset_cycles = 3;
   localparam int idle_extra   = 10;

   localparam logic [3:0] op_end   = 4'h0;
   localparam logic [3:0] op_reset = 4'h1;
   localparam logic [3:0] op_start = 4'h2;
   localparam logic [3:0] op_hit   = 4'h3;
   localparam logic [3:0] op_miss  = 4'h4;
   localparam logic [3:0] op_idle  = 4'h5;

   logic   clk;
   logic   rst_n;
   lamp_t  buttons;
   logic   start;
   rate_t  rate_a;
   rate_t  rate_b;
   lamp_t  lamps;
   state_t state;
   score_t score;

   // opcode, rate_a, rate_b, expected state, expected score
   logic [19:0] steps [max_steps];

   int cycle_count = 0;
   int cycle_limit = 0;
   int pass_count  = 0;
   int fail_count  = 0;
   int step_errors = 0;

   logic [7:0] lfsr_state = 8'd63;

   game_top game_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .buttons (buttons),
      .start   (start),
      .rate_a  (rate_a),
      .rate_b  (rate_b),
      .lamps   (lamps),
      .state   (state),
      .score   (score)
   );

   always #20 clk = ~clk;

   // stop a run that never reaches its end
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("run stopped after %0d cycles, a step never finished", cycle_count);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // x^8 + x^6 + x^5 + x^4 + 1, shifting right
   function automatic logic [7:0] galois_step(input logic [7:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 8'hb8;
      end
      return s >> 1;
   endfunction

   function automatic int step_length(input logic [3:0] op);
      case (op)
         op_reset: return reset_cycles + check_wait;
         op_start: return press_cycles + check_wait;
         op_hit:   return press_cycles + check_wait;
         op_miss:  return press_cycles + check_wait;
         op_idle:  return int'(round_cycles) + idle_extra + check_wait;
         default:  return check_wait;
      endcase
   endfunction

   // one lfsr step per bit taken
   task automatic random_lane_pick(output logic [1:0] pick);
      int i;
      pick = '0;
      for (i = 0; i < 2; i++) begin
         pick       = {pick[0], lfsr_state[0]};
         lfsr_state = galois_step(lfsr_state);
      end
   endtask

   // drive point sits 5 units after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      wait_cycles(reset_cycles);
      rst_n = 1'b1;
   endtask

   task automatic press_buttons(input lamp_t value);
      buttons = value;
      wait_cycles(press_cycles);
      buttons = '0;
   endtask

   task automatic pulse_start();
      start = 1'b1;
      wait_cycles(press_cycles);
      start = 1'b0;
   endtask

   task automatic do_hit();
      if ($countones(lamps) != 1) begin
         $display("hit step found %0d lamps lit instead of one", $countones(lamps));
         step_errors++;
      end
      press_buttons(lamps);
   endtask

   task automatic do_miss();
      lane_t      unlit [4];
      int         count;
      int         i;
      logic [1:0] pick;
      count = 0;
      for (i = 0; i < 4; i++) begin
         if (!lamps[i]) begin
            unlit[count] = lane_t'(i);
            count++;
         end
      end
      random_lane_pick(pick);
      if (count == 0) begin
         $display("miss step found every lamp lit, no wrong button to press");
         step_errors++;
      end
      else begin
         press_buttons(lamp_t'(4'b0001 << unlit[int'(pick) % count]));
      end
   endtask

   task automatic check_step(input logic [19:0] word);
      logic [1:0] exp_state;
      score_t     exp_score;
      exp_state = word[5:4];
      exp_score = word[3:0];
      if (state !== exp_state) begin
         $display("Fail state: expected 0x%0h, got 0x%0h", exp_state, state);
         step_errors++;
      end
      if (score !== exp_score) begin
         $display("Fail score: expected 0x%0h, got 0x%0h", exp_score, score);
         step_errors++;
      end
      if (state == RUN && $countones(lamps) != 1) begin
         $display("%0d lamps lit in RUN, exactly one expected", $countones(lamps));
         step_errors++;
      end
      if (state != RUN && lamps != '0) begin
         $display("lamps lit outside RUN, pattern 0x%0h", lamps);
         step_errors++;
      end
   endtask

   task automatic run_step(input int idx);
      logic [19:0] word;
      logic [3:0]  op;
      string       name;
      word        = steps[idx];
      op          = word[19:16];
      rate_a      = word[15:12];
      rate_b      = word[11:8];
      step_errors = 0;
      case (op)
         op_reset: begin
            name = "reset";
            apply_reset();
         end
         op_start: begin
            name = "start";
            pulse_start();
         end
         op_hit: begin
            name = "hit";
            do_hit();
         end
         op_miss: begin
            name = "miss";
            do_miss();
         end
         op_idle: begin
            name = "idle";
            wait_cycles(int'(round_cycles) + idle_extra);
         end
         default: begin
            name = "unknown";
            $display("step %0d has an unknown opcode 0x%0h", idx, op);
            step_errors++;
         end
      endcase
      wait_cycles(check_wait);
      check_step(word);
      if (step_errors == 0) begin
         pass_count++;
         $display("step %0d %s: ok", idx, name);
      end
      else begin
         fail_count++;
         $display("step %0d %s: %0d errors", idx, name, step_errors);
      end
   endtask

   initial begin
      int i;
      int n_steps;
      int total;
      clk     = 1'b0;
      rst_n   = 1'b0;
      buttons = '0;
      start   = 1'b0;
      rate_a  = '0;
      rate_b  = '0;
      for (i = 0; i < max_steps; i++) begin
         steps[i] = '0;
      end
      $readmemh("verif/game_testdata.txt", steps);

      // list ends at the first zero opcode
      n_steps = 0;
      total   = reset_cycles;
      while (n_steps < max_steps && steps[n_steps][19:16] != op_end) begin
         total += step_length(steps[n_steps][19:16]);
         n_steps++;
      end
      cycle_limit = total * 2 + 100;
      if (n_steps == 0) begin
         $display("data file holds no steps");
         fail_count++;
      end

      wait_cycles(reset_cycles);
      rst_n = 1'b1;
      for (i = 0; i < n_steps; i++) begin
         run_step(i);
      end

      $display("steps passed %0d, steps failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TESTS PASSED");
      end
      else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* verif/game_testdata.txt */
// one hex digit each: opcode, rate_a, rate_b, expected state, expected score
// opcodes 1 reset, 2 start, 3 hit, 4 miss, 5 idle, 0 ends the list
13500
43500
23510
33511
33512
33513
43523
20110
30111
30112
50122
2F710
3F711
3F712
3F713
3F714
3F715
3F716
3F717
3F738
2F710
5F720
21010
21010
41020
1FF00
00000

/* flist.f */
hw/game_pkg.sv
hw/button_sync.sv
hw/tick_divider.sv
hw/random_generator.sv
hw/game_fsm.sv
hw/game_top.sv
verif/tb_game_top.sv

/* run.sh */
#!/bin/sh
# build and run the reaction game testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -f flist.f --top-module tb_game_top -o sim_game

./obj_dir/sim_game > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
   echo "simulation reported failures, see sim.log"
   exit 1
fi

echo "simulation finished without failures"
